// ==== src/mandel_pkg.sv ====
package mandel_pkg;

   //////////////////////////////////////////////////
   // Image and fixed-point format
   //////////////////////////////////////////////////

   // Signed 4.23 fixed point
   localparam int FIX_W  = 27;
   localparam int FRAC_W = 23;

   localparam int IMG_COLS   = 16;
   localparam int IMG_ROWS   = 12;
   localparam int COL_W      = $clog2(IMG_COLS);
   localparam int ROW_W      = $clog2(IMG_ROWS);
   localparam int NUM_PIXELS = IMG_ROWS * IMG_COLS;
   localparam int PIX_W      = $clog2(NUM_PIXELS);

   localparam int MAX_ITER = 255;
   localparam int COUNT_W  = 8;

   localparam int NUM_SOLVERS = 4;
   localparam int SOLVER_W    = (NUM_SOLVERS > 1) ? $clog2(NUM_SOLVERS) : 1;

   typedef logic signed [FIX_W-1:0] fix_t;
   typedef logic [COUNT_W-1:0]      count_t;
   typedef logic [SOLVER_W-1:0]     solver_idx_t;

   // 4.0 in the fixed-point format
   localparam fix_t ESCAPE_LIMIT = fix_t'(4 << FRAC_W);

   localparam logic [COL_W-1:0] LAST_COL   = COL_W'(IMG_COLS - 1);
   localparam logic [ROW_W-1:0] LAST_ROW   = ROW_W'(IMG_ROWS - 1);
   localparam logic [PIX_W-1:0] LAST_PIXEL = PIX_W'(NUM_PIXELS - 1);

   //////////////////////////////////////////////////
   // Bundles
   //////////////////////////////////////////////////

   typedef struct packed {
      fix_t x_0;
      fix_t x_step;
      fix_t y_0;
      fix_t y_step;
   } frame_job_t;

   typedef struct packed {
      logic [ROW_W-1:0] row;
      fix_t             y;
      fix_t             x_0;
      fix_t             x_step;
   } row_task_t;

   typedef struct packed {
      logic [ROW_W-1:0] row;
      logic [COL_W-1:0] col;
      count_t           count;
   } pixel_result_t;

   typedef enum logic [1:0] {IDLE, ITERATE, EMIT} solver_state_t;

   typedef enum logic [1:0] {WAIT_JOB, ISSUE, DRAIN} dispatch_state_t;

endpackage

// ==== src/row_dispatcher.sv ====
`timescale 1ns/10ps

module row_dispatcher (
   input  logic                                                CLOCK_50,
   input  logic                                                reset,
   input  logic                                                job_valid_i,
   input  mandel_pkg::frame_job_t                              job_i,
   output logic                                                job_ready_o,
   output logic [mandel_pkg::NUM_SOLVERS-1:0]                  task_valid_o,
   output mandel_pkg::row_task_t [mandel_pkg::NUM_SOLVERS-1:0] task_o,
   input  logic [mandel_pkg::NUM_SOLVERS-1:0]                  task_ready_i,
   input  logic                                                frame_done_i
);

   mandel_pkg::dispatch_state_t  state;
   mandel_pkg::frame_job_t       job_q;
   logic [mandel_pkg::ROW_W-1:0] next_row;
   mandel_pkg::fix_t             next_y;
   logic                         job_take;
   logic                         issue_fire;

   assign job_ready_o = (state == mandel_pkg::WAIT_JOB);
   assign job_take    = job_valid_i && job_ready_o;
   assign issue_fire  = |(task_valid_o & task_ready_i);

   // Offer the row only to the lowest-indexed ready solver
   always_comb begin
      logic taken;
      taken = 1'b0;
      task_valid_o = '0;
      for (int i = 0; i < mandel_pkg::NUM_SOLVERS; i++) begin
         if (state == mandel_pkg::ISSUE && task_ready_i[i] && !taken) begin
            task_valid_o[i] = 1'b1;
            taken = 1'b1;
         end
      end
   end

   always_comb begin
      for (int i = 0; i < mandel_pkg::NUM_SOLVERS; i++) begin
         task_o[i].row    = next_row;
         task_o[i].y      = next_y;
         task_o[i].x_0    = job_q.x_0;
         task_o[i].x_step = job_q.x_step;
      end
   end

   always_ff @(posedge CLOCK_50) begin
      if (reset) begin
         state    <= mandel_pkg::WAIT_JOB;
         next_row <= '0;
      end else begin
         case (state)
            mandel_pkg::WAIT_JOB: begin
               if (job_take) begin
                  next_row <= '0;
                  state    <= mandel_pkg::ISSUE;
               end
            end
            mandel_pkg::ISSUE: begin
               if (issue_fire) begin
                  next_row <= next_row + 1'b1;
                  if (next_row == mandel_pkg::LAST_ROW)
                     state <= mandel_pkg::DRAIN;
               end
            end
            mandel_pkg::DRAIN: begin
               if (frame_done_i)
                  state <= mandel_pkg::WAIT_JOB;
            end
            default: state <= mandel_pkg::WAIT_JOB;
         endcase
      end
   end

   // Job copy and running y value
   always_ff @(posedge CLOCK_50) begin
      if (job_take) begin
         job_q  <= job_i;
         next_y <= job_i.y_0;
      end else if (issue_fire) begin
         next_y <= next_y + job_q.y_step;
      end
   end

endmodule

// ==== src/row_solver.sv ====
`timescale 1ns/10ps

module row_solver (
   input  logic                      CLOCK_50,
   input  logic                      reset,
   input  logic                      task_valid_i,
   input  mandel_pkg::row_task_t     task_i,
   output logic                      task_ready_o,
   output logic                      res_valid_o,
   output mandel_pkg::pixel_result_t res_o,
   input  logic                      res_ready_i
);

   mandel_pkg::solver_state_t state;

   // Row parameters held for the whole row
   logic [mandel_pkg::ROW_W-1:0] row_q;
   mandel_pkg::fix_t             c_imag;
   mandel_pkg::fix_t             x_step_q;

   // Per-pixel working set
   logic [mandel_pkg::COL_W-1:0] col;
   mandel_pkg::fix_t             c_real;
   mandel_pkg::fix_t             zr;
   mandel_pkg::fix_t             zi;
   mandel_pkg::count_t           count;

   logic signed [2*mandel_pkg::FIX_W-1:0] prod_rr;
   logic signed [2*mandel_pkg::FIX_W-1:0] prod_ii;
   logic signed [2*mandel_pkg::FIX_W-1:0] prod_ri;
   mandel_pkg::fix_t                      zr2;
   mandel_pkg::fix_t                      zi2;
   mandel_pkg::fix_t                      zri;
   logic signed [mandel_pkg::FIX_W:0]     mag;
   mandel_pkg::fix_t                      zr_next;
   mandel_pkg::fix_t                      zi_next;
   logic                                  escape;
   logic                                  task_take;
   logic                                  res_take;
   logic                                  last_col;

   //////////////////////////////////////////////////
   // Escape recurrence datapath
   //////////////////////////////////////////////////

   assign prod_rr = zr * zr;
   assign prod_ii = zi * zi;
   assign prod_ri = zr * zi;

   // Shift right by FRAC_W and keep FIX_W bits
   assign zr2 = prod_rr[mandel_pkg::FRAC_W +: mandel_pkg::FIX_W];
   assign zi2 = prod_ii[mandel_pkg::FRAC_W +: mandel_pkg::FIX_W];
   assign zri = prod_ri[mandel_pkg::FRAC_W +: mandel_pkg::FIX_W];

   // Magnitude one bit wider so the sum cannot wrap
   assign mag = {zr2[mandel_pkg::FIX_W-1], zr2} + {zi2[mandel_pkg::FIX_W-1], zi2};

   assign escape = (mag >= (mandel_pkg::FIX_W + 1)'(mandel_pkg::ESCAPE_LIMIT)) ||
                   (count == mandel_pkg::count_t'(mandel_pkg::MAX_ITER));

   assign zr_next = zr2 - zi2 + c_real;
   assign zi_next = {zri[mandel_pkg::FIX_W-2:0], 1'b0} + c_imag;

   //////////////////////////////////////////////////
   // Handshakes
   //////////////////////////////////////////////////

   assign task_ready_o = (state == mandel_pkg::IDLE);
   assign res_valid_o  = (state == mandel_pkg::EMIT);
   assign task_take    = task_valid_i && task_ready_o;
   assign res_take     = res_valid_o && res_ready_i;
   assign last_col     = (col == mandel_pkg::LAST_COL);

   assign res_o.row   = row_q;
   assign res_o.col   = col;
   assign res_o.count = count;

   always_ff @(posedge CLOCK_50) begin
      if (reset) begin
         state <= mandel_pkg::IDLE;
      end else begin
         case (state)
            mandel_pkg::IDLE: begin
               if (task_take)
                  state <= mandel_pkg::ITERATE;
            end
            mandel_pkg::ITERATE: begin
               if (escape)
                  state <= mandel_pkg::EMIT;
            end
            mandel_pkg::EMIT: begin
               // Wait here until the collector takes the count
               if (res_take)
                  state <= last_col ? mandel_pkg::IDLE : mandel_pkg::ITERATE;
            end
            default: state <= mandel_pkg::IDLE;
         endcase
      end
   end

   // Pixel load, iteration step and column advance
   always_ff @(posedge CLOCK_50) begin
      if (task_take) begin
         row_q    <= task_i.row;
         c_imag   <= task_i.y;
         x_step_q <= task_i.x_step;
         c_real   <= task_i.x_0;
         col      <= '0;
         zr       <= '0;
         zi       <= '0;
         count    <= '0;
      end else if (state == mandel_pkg::ITERATE && !escape) begin
         zr    <= zr_next;
         zi    <= zi_next;
         count <= count + 1'b1;
      end else if (res_take && !last_col) begin
         col    <= col + 1'b1;
         c_real <= c_real + x_step_q;
         zr     <= '0;
         zi     <= '0;
         count  <= '0;
      end
   end

endmodule

// ==== src/result_collector.sv ====
`timescale 1ns/10ps

module result_collector (
   input  logic                                                    CLOCK_50,
   input  logic                                                    reset,
   input  logic [mandel_pkg::NUM_SOLVERS-1:0]                      res_valid_i,
   input  mandel_pkg::pixel_result_t [mandel_pkg::NUM_SOLVERS-1:0] res_i,
   output logic [mandel_pkg::NUM_SOLVERS-1:0]                      res_ready_o,
   input  logic [mandel_pkg::ROW_W-1:0]                            rd_row_i,
   input  logic [mandel_pkg::COL_W-1:0]                            rd_col_i,
   output mandel_pkg::count_t                                      rd_count_o,
   output logic                                                    frame_done_o,
   output logic                                                    done_o
);

   mandel_pkg::count_t frame_mem [mandel_pkg::IMG_ROWS][mandel_pkg::IMG_COLS];

   mandel_pkg::solver_idx_t      last_grant;
   mandel_pkg::solver_idx_t      grant_idx;
   logic                         grant_found;
   mandel_pkg::pixel_result_t    win;
   logic [mandel_pkg::PIX_W-1:0] pix_cnt;
   logic                         done_q;
   mandel_pkg::count_t           rd_count_q;

   //////////////////////////////////////////////////
   // Round-robin grant
   //////////////////////////////////////////////////

   // Search starts one past the previous winner
   always_comb begin
      int idx;
      grant_found = 1'b0;
      grant_idx   = last_grant;
      for (int k = 1; k <= mandel_pkg::NUM_SOLVERS; k++) begin
         idx = (int'(last_grant) + k) % mandel_pkg::NUM_SOLVERS;
         if (!grant_found && res_valid_i[idx]) begin
            grant_found = 1'b1;
            grant_idx   = mandel_pkg::solver_idx_t'(idx);
         end
      end
   end

   always_comb begin
      res_ready_o = '0;
      if (grant_found)
         res_ready_o[grant_idx] = 1'b1;
   end

   assign win = res_i[grant_idx];

   always_ff @(posedge CLOCK_50) begin
      if (reset) begin
         last_grant <= '0;
         pix_cnt    <= '0;
         done_q     <= 1'b0;
      end else begin
         done_q <= 1'b0;
         if (grant_found) begin
            last_grant <= grant_idx;
            if (pix_cnt == mandel_pkg::LAST_PIXEL) begin
               pix_cnt <= '0;
               done_q  <= 1'b1;
            end else begin
               pix_cnt <= pix_cnt + 1'b1;
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // Frame memory
   //////////////////////////////////////////////////

   always_ff @(posedge CLOCK_50) begin
      if (grant_found)
         frame_mem[win.row][win.col] <= win.count;
   end

   // One-cycle read latency
   always_ff @(posedge CLOCK_50) begin
      rd_count_q <= frame_mem[rd_row_i][rd_col_i];
   end

   assign rd_count_o   = rd_count_q;
   assign frame_done_o = done_q;
   assign done_o       = done_q;

endmodule

// ==== src/mandel_top.sv ====
`timescale 1ns/10ps

module mandel_top (
   input  logic                         CLOCK_50,
   input  logic                         reset,
   input  logic                         job_valid_i,
   input  mandel_pkg::frame_job_t       job_i,
   output logic                         job_ready_o,
   input  logic [mandel_pkg::ROW_W-1:0] rd_row_i,
   input  logic [mandel_pkg::COL_W-1:0] rd_col_i,
   output mandel_pkg::count_t           rd_count_o,
   output logic                         done_o
);

   logic [mandel_pkg::NUM_SOLVERS-1:0]                      task_valid;
   mandel_pkg::row_task_t [mandel_pkg::NUM_SOLVERS-1:0]     row_task;
   logic [mandel_pkg::NUM_SOLVERS-1:0]                      task_ready;
   logic [mandel_pkg::NUM_SOLVERS-1:0]                      res_valid;
   mandel_pkg::pixel_result_t [mandel_pkg::NUM_SOLVERS-1:0] res;
   logic [mandel_pkg::NUM_SOLVERS-1:0]                      res_ready;
   logic                                                    frame_done;

   row_dispatcher u_dispatcher (
      .CLOCK_50     (CLOCK_50),
      .reset        (reset),
      .job_valid_i  (job_valid_i),
      .job_i        (job_i),
      .job_ready_o  (job_ready_o),
      .task_valid_o (task_valid),
      .task_o       (row_task),
      .task_ready_i (task_ready),
      .frame_done_i (frame_done)
   );

   // Identical solvers, one row each
   for (genvar i = 0; i < mandel_pkg::NUM_SOLVERS; i++) begin : g_solver
      row_solver u_solver (
         .CLOCK_50     (CLOCK_50),
         .reset        (reset),
         .task_valid_i (task_valid[i]),
         .task_i       (row_task[i]),
         .task_ready_o (task_ready[i]),
         .res_valid_o  (res_valid[i]),
         .res_o        (res[i]),
         .res_ready_i  (res_ready[i])
      );
   end

   result_collector u_collector (
      .CLOCK_50     (CLOCK_50),
      .reset        (reset),
      .res_valid_i  (res_valid),
      .res_i        (res),
      .res_ready_o  (res_ready),
      .rd_row_i     (rd_row_i),
      .rd_col_i     (rd_col_i),
      .rd_count_o   (rd_count_o),
      .frame_done_o (frame_done),
      .done_o       (done_o)
   );

endmodule

// ==== tb/mandel_model.svh ====
`ifndef MANDEL_MODEL_SVH
`define MANDEL_MODEL_SVH

//////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////

// Keep the low FIX_W bits as a signed value
function automatic longint wrap_fix(input longint v);
   mandel_pkg::fix_t t;
   t = mandel_pkg::fix_t'(v);
   return longint'(t);
endfunction

// Escape count of one point with one recurrence step per pass
function automatic int escape_count(input longint c_re, input longint c_im);
   longint zr;
   longint zi;
   longint zr2;
   longint zi2;
   longint zri;
   longint limit;
   int     n;
   logic   stop;
   zr    = 0;
   zi    = 0;
   n     = 0;
   stop  = 1'b0;
   limit = longint'(4) << mandel_pkg::FRAC_W;
   while (!stop) begin
      zr2 = wrap_fix((zr * zr) >>> mandel_pkg::FRAC_W);
      zi2 = wrap_fix((zi * zi) >>> mandel_pkg::FRAC_W);
      zri = wrap_fix((zr * zi) >>> mandel_pkg::FRAC_W);
      // Sum of two FIX_W words never wraps here
      if (zr2 + zi2 >= limit || n == mandel_pkg::MAX_ITER) begin
         stop = 1'b1;
      end else begin
         zr = wrap_fix(zr2 - zi2 + c_re);
         zi = wrap_fix(2 * zri + c_im);
         n++;
      end
   end
   return n;
endfunction

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
   logic fb;
   fb = s[31] ^ s[21] ^ s[1] ^ s[0];
   return {s[30:0], fb};
endfunction

// Read the whole frame and compare with the model
task automatic compare_frame(input mandel_pkg::frame_job_t j, input int expect_all,
                             output int n_max);
   longint             c_re;
   longint             c_im;
   mandel_pkg::count_t got;
   int                 exp_n;
   n_max = 0;
   c_im  = wrap_fix(longint'(j.y_0));
   for (int r = 0; r < mandel_pkg::IMG_ROWS; r++) begin
      c_re = wrap_fix(longint'(j.x_0));
      for (int c = 0; c < mandel_pkg::IMG_COLS; c++) begin
         exp_n = escape_count(c_re, c_im);
         if (exp_n == mandel_pkg::MAX_ITER)
            n_max++;
         if (expect_all >= 0)
            assert (exp_n == expect_all) else
               stop_on_error($sformatf("model gives %0d at row %0d col %0d, expected %0d",
                                       exp_n, r, c, expect_all));
         read_pixel(r, c, got);
         assert (int'(got) == exp_n) else
            stop_on_error($sformatf("count at row %0d col %0d is %0d, expected %0d",
                                    r, c, got, exp_n));
         c_re = wrap_fix(c_re + longint'(j.x_step));
      end
      c_im = wrap_fix(c_im + longint'(j.y_step));
   end
endtask

`endif

// ==== tb/mandel_tb.sv ====
`timescale 1ns/10ps

module mandel_tb;

   typedef logic [mandel_pkg::ROW_W-1:0] row_idx_t;
   typedef logic [mandel_pkg::COL_W-1:0] col_idx_t;

   // Three frames at the worst case iteration count
   localparam int TIMEOUT_CYCLES = 3 * mandel_pkg::IMG_ROWS * mandel_pkg::IMG_COLS *
                                   (mandel_pkg::MAX_ITER + 3);
   localparam int NUM_FRAMES = 6;

   logic                   CLOCK_50;
   logic                   reset;
   logic                   job_valid_i;
   mandel_pkg::frame_job_t job_i;
   logic                   job_ready_o;
   row_idx_t               rd_row_i;
   col_idx_t               rd_col_i;
   mandel_pkg::count_t     rd_count_o;
   logic                   done_o;

   int          errors;
   int          cycles;
   int          frames_taken;
   int          frames_done;
   logic        busy;
   logic        done_prev;
   logic [31:0] lfsr_state;

   mandel_top DUT (
      .CLOCK_50    (CLOCK_50),
      .reset       (reset),
      .job_valid_i (job_valid_i),
      .job_i       (job_i),
      .job_ready_o (job_ready_o),
      .rd_row_i    (rd_row_i),
      .rd_col_i    (rd_col_i),
      .rd_count_o  (rd_count_o),
      .done_o      (done_o)
   );

   task automatic stop_on_error(input string msg);
      errors++;
      $display("Fail at time %0t: %s", $time, msg);
      $display("TEST FAIL");
      $fatal(1, "stopped at first error");
   endtask

   // Address out, one edge to latch, then sample
   task automatic read_pixel(input int r, input int c, output mandel_pkg::count_t v);
      @(posedge CLOCK_50);
      rd_row_i <= row_idx_t'(r);
      rd_col_i <= col_idx_t'(c);
      @(posedge CLOCK_50);
      @(posedge CLOCK_50);
      v = rd_count_o;
   endtask

   `include "mandel_model.svh"

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
   endtask

   function automatic mandel_pkg::frame_job_t make_job(input int x0, input int xs,
                                                       input int y0, input int ys);
      mandel_pkg::frame_job_t j;
      j.x_0    = mandel_pkg::fix_t'(x0);
      j.x_step = mandel_pkg::fix_t'(xs);
      j.y_0    = mandel_pkg::fix_t'(y0);
      j.y_step = mandel_pkg::fix_t'(ys);
      return j;
   endfunction

   // Origin near the left of the set and steps between about 1/32 and 1/16
   task automatic random_job(output mandel_pkg::frame_job_t j);
      logic [31:0] bits;
      take_bits(23, bits);
      j.x_0 = mandel_pkg::fix_t'(-(2 << 23)) + mandel_pkg::fix_t'(bits[22:0]);
      take_bits(20, bits);
      j.y_0 = mandel_pkg::fix_t'(-(5 << 21)) + mandel_pkg::fix_t'(bits[19:0]);
      take_bits(18, bits);
      j.x_step = mandel_pkg::fix_t'(1 << 18) + mandel_pkg::fix_t'(bits[17:0]);
      take_bits(18, bits);
      j.y_step = mandel_pkg::fix_t'(1 << 18) + mandel_pkg::fix_t'(bits[17:0]);
   endtask

   // Returns at the edge where the job is taken
   task automatic offer_job(input mandel_pkg::frame_job_t j);
      @(posedge CLOCK_50);
      job_valid_i <= 1'b1;
      job_i       <= j;
      do @(posedge CLOCK_50); while (!job_ready_o);
      job_valid_i <= 1'b0;
   endtask

   task automatic wait_done();
      do @(posedge CLOCK_50); while (!done_o);
   endtask

   task automatic run_job(input mandel_pkg::frame_job_t j);
      offer_job(j);
      wait_done();
   endtask

   initial begin
      CLOCK_50 = 1'b0;
      forever #10 CLOCK_50 = ~CLOCK_50;
   end

   //////////////////////////////////////////////////
   // Watchdog and protocol monitor
   //////////////////////////////////////////////////

   always @(posedge CLOCK_50) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Timeout: run still going after %0d cycles", cycles);
         $display("TEST FAIL");
         $fatal(1, "simulation timed out");
      end
   end

   always @(posedge CLOCK_50) begin
      if (!reset) begin
         assert (!(done_o && done_prev)) else stop_on_error("done_o longer than one cycle");
         assert (!(done_o && !busy)) else stop_on_error("done_o without a running frame");
         assert (!(busy && job_ready_o)) else stop_on_error("job_ready_o high during a frame");
         if (done_o) begin
            busy = 1'b0;
            frames_done++;
         end
         if (job_valid_i && job_ready_o) begin
            busy = 1'b1;
            frames_taken++;
         end
         done_prev = done_o;
      end
   end

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial begin
      mandel_pkg::frame_job_t base_job;
      mandel_pkg::frame_job_t far_job;
      mandel_pkg::frame_job_t rand_job;
      int                     n_max;
      reset        = 1'b1;
      job_valid_i  = 1'b0;
      job_i        = '0;
      rd_row_i     = '0;
      rd_col_i     = '0;
      errors       = 0;
      cycles       = 0;
      frames_taken = 0;
      frames_done  = 0;
      busy         = 1'b0;
      done_prev    = 1'b0;
      lfsr_state   = 32'h7fa;

      repeat (10) @(posedge CLOCK_50);
      reset <= 1'b0;
      @(posedge CLOCK_50);
      assert (job_ready_o) else stop_on_error("job_ready_o low after reset");
      assert (!done_o) else stop_on_error("done_o high after reset");

      // Main set with x from -2.0 by 5/32 and y from -1.25 by 7/32
      base_job = make_job(-(2 << 23), 5 << 18, -(5 << 21), 7 << 18);
      run_job(base_job);
      compare_frame(base_job, -1, n_max);
      assert (n_max > 0) else stop_on_error("base view has no point inside the set");

      // Every point escapes on the second step
      far_job = make_job(9 << 21, 1 << 17, 9 << 21, 1 << 17);
      run_job(far_job);
      compare_frame(far_job, 1, n_max);

      // Second copy held valid while the first frame runs
      offer_job(base_job);
      @(posedge CLOCK_50);
      job_valid_i <= 1'b1;
      wait_done();
      @(posedge CLOCK_50);
      assert (job_ready_o) else stop_on_error("held job not taken after done_o");
      job_valid_i <= 1'b0;
      wait_done();
      compare_frame(base_job, -1, n_max);

      random_job(rand_job);
      run_job(rand_job);
      compare_frame(rand_job, -1, n_max);
      random_job(rand_job);
      run_job(rand_job);
      compare_frame(rand_job, -1, n_max);

      @(negedge CLOCK_50);
      assert (frames_taken == NUM_FRAMES && frames_done == NUM_FRAMES) else
         stop_on_error($sformatf("%0d jobs taken and %0d frames done, expected %0d",
                                 frames_taken, frames_done, NUM_FRAMES));

      if (errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

// ==== src.f ====
+incdir+tb
src/mandel_pkg.sv
src/row_dispatcher.sv
src/row_solver.sv
src/result_collector.sv
src/mandel_top.sv
tb/mandel_tb.sv

// ==== Makefile ====
TOP = mandel_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST PASS" sim.log || (echo "Simulation ended without a result"; exit 1)

obj_dir/V$(TOP): src.f $(wildcard src/*.sv) tb/mandel_tb.sv tb/mandel_model.svh
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module mandel_top

clean:
	rm -rf obj_dir sim.log
